/* rtl/tlb_consts.svh */
`ifndef TLB_CONSTS_SVH
`define TLB_CONSTS_SVH

// tlb geometry
`define TLB_NUM     16
`define TLB_IDX_W   4

// entry field widths
`define VPPN_W      19
`define PPN_W       20
`define ASID_W      10

// tlb related csr numbers
`define CSR_TLBIDX  14'h10
`define CSR_TLBEHI  14'h11
`define CSR_TLBELO0 14'h12
`define CSR_TLBELO1 14'h13
`define CSR_ASID    14'h18

`define LFSR_SEED   4'b0001 // tlbfill index generator

`endif

/* rtl/tlb_pkg.sv */
`default_nettype none

`include "tlb_consts.svh"

package tlb_pkg;

    // what the writeback stage does with the instruction it holds
    typedef enum logic [2:0] {
        OP_ALU,
        OP_CSRRD,
        OP_CSRWR,
        OP_TLBSRCH,
        OP_TLBRD,
        OP_TLBWR,
        OP_TLBFILL,
        OP_INVTLB
    } wb_op_t;

    // one tlb entry, 89 bits, even page then odd page
    typedef struct packed {
        logic                e;
        logic [`VPPN_W-1:0]  vppn;
        logic [5:0]          ps;
        logic [`ASID_W-1:0]  asid;
        logic                g;
        logic [`PPN_W-1:0]   ppn0;
        logic [1:0]          plv0;
        logic [1:0]          mat0;
        logic                d0;
        logic                v0;
        logic [`PPN_W-1:0]   ppn1;
        logic [1:0]          plv1;
        logic [1:0]          mat1;
        logic                d1;
        logic                v1;
    } tlb_entry_t;

endpackage

`default_nettype wire

/* rtl/tlb_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_consts.svh"

// write and invalidate command, stage to every entry
interface tlb_write_if;
    import tlb_pkg::*;

    logic                  we;
    logic [`TLB_IDX_W-1:0] index;
    tlb_entry_t            wr_entry;
    logic                  inv;      // invalidate by asid
    logic [`ASID_W-1:0]    inv_asid;

    modport stage (
        output we, index, wr_entry, inv, inv_asid
    );

    modport entry (
        input we, index, wr_entry, inv, inv_asid
    );
endinterface

// search and read port between csrs and match/select
interface tlb_lookup_if;
    import tlb_pkg::*;

    logic [`VPPN_W-1:0]    s_vppn;
    logic [`ASID_W-1:0]    s_asid;
    logic                  found;
    logic [`TLB_IDX_W-1:0] s_index;
    logic [`TLB_IDX_W-1:0] r_index;
    tlb_entry_t            r_entry;

    modport csr (
        output s_vppn, s_asid, r_index,
        input  found, s_index, r_entry
    );

    modport sel (
        input  r_index,
        output found, s_index, r_entry
    );
endinterface

`default_nettype wire

/* rtl/wb_tlb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_consts.svh"

module wb_tlb_stage (
    input  wire                   clk,
    input  wire                   reset,

    input  wire                   in_valid,
    input  wire tlb_pkg::wb_op_t  in_op,
    input  wire  [31:0]           in_pc,
    input  wire  [31:0]           in_result,
    input  wire  [4:0]            in_dest,
    input  wire  [13:0]           in_csr_num,

    // csr access
    input  wire  [31:0]           csr_rvalue,
    output logic                  csr_we,
    output logic [13:0]           csr_num,
    output logic [31:0]           csr_wvalue,
    output logic                  srch_commit,
    output logic                  rd_commit,

    tlb_write_if.stage            tw,

    // csr image for tlbwr / tlbfill
    input  wire  [`TLB_IDX_W-1:0] tlbidx_index,
    input  wire  [5:0]            tlbidx_ps,
    input  wire                   tlbidx_ne,
    input  wire  [`VPPN_W-1:0]    tlbehi_vppn,
    input  wire  [`ASID_W-1:0]    asid,
    input  wire  [31:0]           elo0,
    input  wire  [31:0]           elo1,

    output logic                  rf_we,
    output logic [4:0]            rf_waddr,
    output logic [31:0]           rf_wdata,
    output logic [31:0]           debug_wb_pc
);
    import tlb_pkg::*;

    logic                  wb_valid;
    wb_op_t                wb_op;
    logic [31:0]           wb_pc;
    logic [31:0]           wb_result;
    logic [4:0]            wb_dest;
    logic [13:0]           wb_csr_num;

    logic                  is_alu;
    logic                  is_csrrd;
    logic                  is_tlbwr;
    logic                  is_tlbfill;
    logic [`TLB_IDX_W-1:0] lfsr;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= in_valid;
        end
    end

    // payload only moves on a valid instruction
    always_ff @(posedge clk) begin
        if (in_valid) begin
            wb_op      <= in_op;
            wb_pc      <= in_pc;
            wb_result  <= in_result;
            wb_dest    <= in_dest;
            wb_csr_num <= in_csr_num;
        end
    end

    assign is_alu     = wb_valid && (wb_op == OP_ALU);
    assign is_csrrd   = wb_valid && (wb_op == OP_CSRRD);
    assign is_tlbwr   = wb_valid && (wb_op == OP_TLBWR);
    assign is_tlbfill = wb_valid && (wb_op == OP_TLBFILL);

    // register file result
    assign rf_we       = (is_alu || is_csrrd) && (wb_dest != 5'd0);
    assign rf_waddr    = wb_dest;
    assign rf_wdata    = is_csrrd ? csr_rvalue : wb_result;
    assign debug_wb_pc = wb_pc;

    assign csr_num     = wb_csr_num;
    assign csr_we      = wb_valid && (wb_op == OP_CSRWR);
    assign csr_wvalue  = wb_result;
    assign srch_commit = wb_valid && (wb_op == OP_TLBSRCH);
    assign rd_commit   = wb_valid && (wb_op == OP_TLBRD);

    // fill index, steps only when a fill commits
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= `LFSR_SEED;
        end else if (is_tlbfill) begin
            lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
        end
    end

    assign tw.we       = is_tlbwr || is_tlbfill;
    assign tw.index    = is_tlbwr ? tlbidx_index : lfsr;
    assign tw.inv      = wb_valid && (wb_op == OP_INVTLB);
    assign tw.inv_asid = wb_result[`ASID_W-1:0]; // rj operand

    // new entry from the csr image
    always_comb begin
        tw.wr_entry.e    = ~tlbidx_ne;
        tw.wr_entry.vppn = tlbehi_vppn;
        tw.wr_entry.ps   = tlbidx_ps;
        tw.wr_entry.asid = asid;
        tw.wr_entry.g    = elo0[6] & elo1[6]; // global only if both halves agree
        tw.wr_entry.ppn0 = elo0[27:8];
        tw.wr_entry.plv0 = elo0[3:2];
        tw.wr_entry.mat0 = elo0[5:4];
        tw.wr_entry.d0   = elo0[1];
        tw.wr_entry.v0   = elo0[0];
        tw.wr_entry.ppn1 = elo1[27:8];
        tw.wr_entry.plv1 = elo1[3:2];
        tw.wr_entry.mat1 = elo1[5:4];
        tw.wr_entry.d1   = elo1[1];
        tw.wr_entry.v1   = elo1[0];
    end

endmodule

`default_nettype wire

/* rtl/tlb_csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_consts.svh"

module tlb_csr_file (
    input  wire                   clk,
    input  wire                   reset,

    input  wire                   csr_we,
    input  wire  [13:0]           csr_num,
    input  wire  [31:0]           csr_wvalue,
    input  wire                   srch_commit,
    input  wire                   rd_commit,
    output logic [31:0]           csr_rvalue,

    tlb_lookup_if.csr             lk,

    output logic [`TLB_IDX_W-1:0] tlbidx_index,
    output logic [5:0]            tlbidx_ps,
    output logic                  tlbidx_ne,
    output logic [`VPPN_W-1:0]    tlbehi_vppn,
    output logic [`ASID_W-1:0]    asid,
    output logic [31:0]           elo0,
    output logic [31:0]           elo1
);
    import tlb_pkg::*;

    localparam logic [31:0] ELO_MASK = 32'h0fff_ff7f; // ppn, g, mat, plv, d, v

    tlb_entry_t rd;

    function automatic logic [31:0] pack_elo(
        input logic [`PPN_W-1:0] ppn,
        input logic              g,
        input logic [1:0]        mat,
        input logic [1:0]        plv,
        input logic              d,
        input logic              v
    );
        pack_elo = {4'b0, ppn, 1'b0, g, mat, plv, d, v};
    endfunction

    assign rd = lk.r_entry;

    assign lk.s_vppn  = tlbehi_vppn;
    assign lk.s_asid  = asid;
    assign lk.r_index = tlbidx_index;

    always_ff @(posedge clk) begin
        if (reset) begin
            tlbidx_index <= '0;
            tlbidx_ps    <= '0;
            tlbidx_ne    <= 1'b0;
            tlbehi_vppn  <= '0;
            asid         <= '0;
            elo0         <= '0;
            elo1         <= '0;
        end else if (csr_we) begin
            case (csr_num)
                `CSR_TLBIDX: begin
                    tlbidx_index <= csr_wvalue[`TLB_IDX_W-1:0];
                    tlbidx_ps    <= csr_wvalue[29:24];
                    tlbidx_ne    <= csr_wvalue[31];
                end
                `CSR_TLBEHI:  tlbehi_vppn <= csr_wvalue[31:13];
                `CSR_TLBELO0: elo0 <= csr_wvalue & ELO_MASK;
                `CSR_TLBELO1: elo1 <= csr_wvalue & ELO_MASK;
                `CSR_ASID:    asid <= csr_wvalue[`ASID_W-1:0];
                default: ;
            endcase
        end else if (srch_commit) begin
            if (lk.found) begin
                tlbidx_index <= lk.s_index;
                tlbidx_ne    <= 1'b0;
            end else begin
                tlbidx_ne <= 1'b1; // index left alone on a miss
            end
        end else if (rd_commit) begin
            if (rd.e) begin
                tlbidx_ps   <= rd.ps;
                tlbidx_ne   <= 1'b0;
                tlbehi_vppn <= rd.vppn;
                asid        <= rd.asid;
                elo0 <= pack_elo(rd.ppn0, rd.g, rd.mat0, rd.plv0, rd.d0, rd.v0);
                elo1 <= pack_elo(rd.ppn1, rd.g, rd.mat1, rd.plv1, rd.d1, rd.v1);
            end else begin
                // empty slot reads back as all zero
                tlbidx_ps   <= '0;
                tlbidx_ne   <= 1'b1;
                tlbehi_vppn <= '0;
                asid        <= '0;
                elo0        <= '0;
                elo1        <= '0;
            end
        end
    end

    always_comb begin
        case (csr_num)
            `CSR_TLBIDX:  csr_rvalue = {tlbidx_ne, 1'b0, tlbidx_ps,
                                        {(24 - `TLB_IDX_W){1'b0}}, tlbidx_index};
            `CSR_TLBEHI:  csr_rvalue = {tlbehi_vppn, 13'b0};
            `CSR_TLBELO0: csr_rvalue = elo0;
            `CSR_TLBELO1: csr_rvalue = elo1;
            `CSR_ASID:    csr_rvalue = {{(32 - `ASID_W){1'b0}}, asid};
            default:      csr_rvalue = 32'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/tlb_entry.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_consts.svh"

module tlb_entry (
    input  wire                   clk,
    input  wire                   reset,
    input  wire  [`TLB_IDX_W-1:0] index_id, // own slot number

    tlb_write_if.entry            tw,

    input  wire  [`VPPN_W-1:0]    s_vppn,
    input  wire  [`ASID_W-1:0]    s_asid,
    output logic                  hit,
    output tlb_pkg::tlb_entry_t   value
);
    import tlb_pkg::*;

    tlb_entry_t ent;
    logic       asid_ok;
    logic       vppn_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            ent.e <= 1'b0;
        end else if (tw.we && (tw.index == index_id)) begin
            ent <= tw.wr_entry;
        end else if (tw.inv && !ent.g && (ent.asid == tw.inv_asid)) begin
            ent.e <= 1'b0; // globals survive invtlb
        end
    end

    assign asid_ok = ent.g || (ent.asid == s_asid);

    // 4MB page ignores the low vppn bits
    always_comb begin
        if (ent.ps == 6'd21) begin
            vppn_ok = (ent.vppn[18:9] == s_vppn[18:9]);
        end else begin
            vppn_ok = (ent.vppn == s_vppn);
        end
    end

    assign hit   = ent.e && asid_ok && vppn_ok;
    assign value = ent;

endmodule

`default_nettype wire

/* rtl/tlb_match_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_consts.svh"

module tlb_match_select (
    input  wire                 [`TLB_NUM-1:0] hits,
    input  wire tlb_pkg::tlb_entry_t           values [`TLB_NUM],
    tlb_lookup_if.sel                          lk
);
    import tlb_pkg::*;

    assign lk.found = |hits;

    // lowest hit wins
    always_comb begin
        lk.s_index = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (hits[i]) begin
                lk.s_index = i[`TLB_IDX_W-1:0];
            end
        end
    end

    // tlbrd port
    assign lk.r_entry = values[lk.r_index];

endmodule

`default_nettype wire

/* rtl/tlb_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_consts.svh"

module tlb_wb_top (
    input  wire                  clk,
    input  wire                  reset,

    input  wire                  in_valid,
    input  wire tlb_pkg::wb_op_t in_op,
    input  wire  [31:0]          in_pc,
    input  wire  [31:0]          in_result,
    input  wire  [4:0]           in_dest,
    input  wire  [13:0]          in_csr_num,

    output logic                 rf_we,
    output logic [4:0]           rf_waddr,
    output logic [31:0]          rf_wdata,
    output logic [31:0]          debug_wb_pc
);
    import tlb_pkg::*;

    logic                  csr_we;
    logic [13:0]           csr_num;
    logic [31:0]           csr_wvalue;
    logic [31:0]           csr_rvalue;
    logic                  srch_commit;
    logic                  rd_commit;

    logic [`TLB_IDX_W-1:0] tlbidx_index;
    logic [5:0]            tlbidx_ps;
    logic                  tlbidx_ne;
    logic [`VPPN_W-1:0]    tlbehi_vppn;
    logic [`ASID_W-1:0]    asid;
    logic [31:0]           elo0;
    logic [31:0]           elo1;

    logic [`TLB_NUM-1:0]   hits;
    tlb_entry_t            values [`TLB_NUM];

    tlb_write_if  tw ();
    tlb_lookup_if lk ();

    wb_tlb_stage u_stage (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_pc        (in_pc),
        .in_result    (in_result),
        .in_dest      (in_dest),
        .in_csr_num   (in_csr_num),
        .csr_rvalue   (csr_rvalue),
        .csr_we       (csr_we),
        .csr_num      (csr_num),
        .csr_wvalue   (csr_wvalue),
        .srch_commit  (srch_commit),
        .rd_commit    (rd_commit),
        .tw           (tw.stage),
        .tlbidx_index (tlbidx_index),
        .tlbidx_ps    (tlbidx_ps),
        .tlbidx_ne    (tlbidx_ne),
        .tlbehi_vppn  (tlbehi_vppn),
        .asid         (asid),
        .elo0         (elo0),
        .elo1         (elo1),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .debug_wb_pc  (debug_wb_pc)
    );

    tlb_csr_file u_csr (
        .clk          (clk),
        .reset        (reset),
        .csr_we       (csr_we),
        .csr_num      (csr_num),
        .csr_wvalue   (csr_wvalue),
        .srch_commit  (srch_commit),
        .rd_commit    (rd_commit),
        .csr_rvalue   (csr_rvalue),
        .lk           (lk.csr),
        .tlbidx_index (tlbidx_index),
        .tlbidx_ps    (tlbidx_ps),
        .tlbidx_ne    (tlbidx_ne),
        .tlbehi_vppn  (tlbehi_vppn),
        .asid         (asid),
        .elo0         (elo0),
        .elo1         (elo1)
    );

    // search key comes straight from tlbehi / asid
    for (genvar i = 0; i < `TLB_NUM; i++) begin : g_entry
        localparam logic [`TLB_IDX_W-1:0] ID = i;

        tlb_entry u_entry (
            .clk      (clk),
            .reset    (reset),
            .index_id (ID),
            .tw       (tw.entry),
            .s_vppn   (lk.s_vppn),
            .s_asid   (lk.s_asid),
            .hit      (hits[i]),
            .value    (values[i])
        );
    end

    tlb_match_select u_sel (
        .hits   (hits),
        .values (values),
        .lk     (lk.sel)
    );

endmodule

`default_nettype wire

/* sim/tb_tlb_ref.svh */
`ifndef TB_TLB_REF_SVH
`define TB_TLB_REF_SVH

// model of the tlb array, the five csrs and the fill lfsr
tlb_entry_t            m_tlb [`TLB_NUM];
logic [`TLB_IDX_W-1:0] m_idx;
logic [5:0]            m_ps;
logic                  m_ne;
logic [`VPPN_W-1:0]    m_vppn;
logic [`ASID_W-1:0]    m_asid;
logic [31:0]           m_elo0;
logic [31:0]           m_elo1;
logic [`TLB_IDX_W-1:0] m_lfsr;

task automatic ref_reset();
    for (int i = 0; i < `TLB_NUM; i++) begin
        m_tlb[i] = '0;
    end
    m_idx  = '0;
    m_ps   = '0;
    m_ne   = 1'b0;
    m_vppn = '0;
    m_asid = '0;
    m_elo0 = '0;
    m_elo1 = '0;
    m_lfsr = `LFSR_SEED;
endtask

function automatic logic [31:0] ref_csr_read(input logic [13:0] num);
    logic [31:0] v;
    v = '0;
    case (num)
        `CSR_TLBIDX: begin
            v[3:0]   = m_idx;
            v[29:24] = m_ps;
            v[31]    = m_ne;
        end
        `CSR_TLBEHI:  v[31:13] = m_vppn;
        `CSR_TLBELO0: v = m_elo0;
        `CSR_TLBELO1: v = m_elo1;
        `CSR_ASID:    v[9:0] = m_asid;
        default: ;
    endcase
    return v;
endfunction

task automatic ref_csr_write(input logic [13:0] num, input logic [31:0] v);
    case (num)
        `CSR_TLBIDX: begin
            m_idx = v[3:0];
            m_ps  = v[29:24];
            m_ne  = v[31];
        end
        `CSR_TLBEHI:  m_vppn = v[31:13];
        `CSR_TLBELO0: m_elo0 = v & 32'h0fff_ff7f; // v d plv mat g ppn
        `CSR_TLBELO1: m_elo1 = v & 32'h0fff_ff7f;
        `CSR_ASID:    m_asid = v[9:0];
        default: ;
    endcase
endtask

function automatic logic ref_rf_we(input wb_op_t op, input logic [4:0] dest);
    return ((op == OP_ALU) || (op == OP_CSRRD)) && (dest != 5'd0);
endfunction

function automatic logic [31:0] ref_rf_wdata(input wb_op_t op, input logic [31:0] result,
                                             input logic [13:0] num);
    return (op == OP_CSRRD) ? ref_csr_read(num) : result;
endfunction

function automatic logic ref_hit(input tlb_entry_t ent);
    logic vppn_eq;
    if (ent.ps == 6'd21) begin
        vppn_eq = (ent.vppn[18:9] == m_vppn[18:9]);
    end else begin
        vppn_eq = (ent.vppn == m_vppn);
    end
    return ent.e && (ent.g || (ent.asid == m_asid)) && vppn_eq;
endfunction

function automatic logic [31:0] ref_elo(input logic [19:0] ppn, input logic [1:0] plv,
                                        input logic [1:0] mat, input logic g,
                                        input logic d, input logic v);
    logic [31:0] elo;
    elo       = '0;
    elo[0]    = v;
    elo[1]    = d;
    elo[3:2]  = plv;
    elo[5:4]  = mat;
    elo[6]    = g;
    elo[27:8] = ppn;
    return elo;
endfunction

function automatic tlb_entry_t ref_new_entry();
    tlb_entry_t ent;
    ent.e    = ~m_ne;
    ent.vppn = m_vppn;
    ent.ps   = m_ps;
    ent.asid = m_asid;
    ent.g    = m_elo0[6] & m_elo1[6];
    ent.ppn0 = m_elo0[27:8];
    ent.plv0 = m_elo0[3:2];
    ent.mat0 = m_elo0[5:4];
    ent.d0   = m_elo0[1];
    ent.v0   = m_elo0[0];
    ent.ppn1 = m_elo1[27:8];
    ent.plv1 = m_elo1[3:2];
    ent.mat1 = m_elo1[5:4];
    ent.d1   = m_elo1[1];
    ent.v1   = m_elo1[0];
    return ent;
endfunction

// state change of one committed instruction
task automatic ref_commit(input wb_op_t op, input logic [31:0] result, input logic [13:0] num);
    int         hit_idx;
    tlb_entry_t ent;
    case (op)
        OP_CSRWR: ref_csr_write(num, result);
        OP_TLBSRCH: begin
            hit_idx = -1;
            for (int i = `TLB_NUM - 1; i >= 0; i--) begin
                if (ref_hit(m_tlb[i])) begin
                    hit_idx = i;
                end
            end
            if (hit_idx >= 0) begin
                m_idx = hit_idx[3:0];
                m_ne  = 1'b0;
            end else begin
                m_ne = 1'b1;
            end
        end
        OP_TLBRD: begin
            ent = m_tlb[m_idx];
            if (ent.e) begin
                m_ps   = ent.ps;
                m_ne   = 1'b0;
                m_vppn = ent.vppn;
                m_asid = ent.asid;
                m_elo0 = ref_elo(ent.ppn0, ent.plv0, ent.mat0, ent.g, ent.d0, ent.v0);
                m_elo1 = ref_elo(ent.ppn1, ent.plv1, ent.mat1, ent.g, ent.d1, ent.v1);
            end else begin
                m_ps   = '0;
                m_ne   = 1'b1;
                m_vppn = '0;
                m_asid = '0;
                m_elo0 = '0;
                m_elo1 = '0;
            end
        end
        OP_TLBWR: m_tlb[m_idx] = ref_new_entry();
        OP_TLBFILL: begin
            m_tlb[m_lfsr] = ref_new_entry();
            m_lfsr = {m_lfsr[2:0], m_lfsr[3] ^ m_lfsr[2]};
        end
        OP_INVTLB: begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                if (!m_tlb[i].g && (m_tlb[i].asid == result[9:0])) begin
                    m_tlb[i].e = 1'b0;
                end
            end
        end
        default: ;
    endcase
endtask

`endif

/* sim/tb_tlb_wb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_consts.svh"

module tb_tlb_wb;
    import tlb_pkg::*;

    typedef struct packed {
        wb_op_t      op;
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic [31:0] pc;
    } exp_t;

    logic        clk;
    logic        reset;
    logic        in_valid;
    wb_op_t      in_op;
    logic [31:0] in_pc;
    logic [31:0] in_result;
    logic [4:0]  in_dest;
    logic [13:0] in_csr_num;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic [31:0] debug_wb_pc;

    integer      seed;
    logic [31:0] pc_next;
    logic [13:0] csr_list [5];
    exp_t        exp_q [$];
    int          issued;
    int          checked;

    `include "tb_tlb_ref.svh"

    tlb_wb_top uut (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_pc       (in_pc),
        .in_result   (in_result),
        .in_dest     (in_dest),
        .in_csr_num  (in_csr_num),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .debug_wb_pc (debug_wb_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_op      = OP_ALU;
        in_pc      = '0;
        in_result  = '0;
        in_dest    = '0;
        in_csr_num = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_rf(input logic exp_we, input logic [4:0] exp_waddr,
                            input logic [31:0] exp_wdata, input string tag);
        if (rf_we !== exp_we) begin
            fail_now($sformatf("MISMATCH at %0t: %s rf_we %b, expected %b",
                               $time, tag, rf_we, exp_we));
        end else if (exp_we && (rf_waddr !== exp_waddr)) begin
            fail_now($sformatf("MISMATCH at %0t: %s rf_waddr %0d, expected %0d",
                               $time, tag, rf_waddr, exp_waddr));
        end else if (exp_we && (rf_wdata !== exp_wdata)) begin
            fail_now($sformatf("MISMATCH at %0t: %s rf_wdata %h, expected %h",
                               $time, tag, rf_wdata, exp_wdata));
        end
    endtask

    task automatic check_pc(input logic [31:0] exp_pc, input string tag);
        if (debug_wb_pc !== exp_pc) begin
            fail_now($sformatf("MISMATCH at %0t: %s debug_wb_pc %h, expected %h",
                               $time, tag, debug_wb_pc, exp_pc));
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                fail_now("timeout: reset was never released");
            end
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (checked != issued) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                fail_now("timeout: issued instructions never reached writeback");
            end
        end
    endtask

    task automatic issue(input wb_op_t op, input logic [31:0] result,
                         input logic [4:0] dest, input logic [13:0] num);
        exp_t e;
        @(posedge clk);
        #2;
        in_valid   = 1'b1;
        in_op      = op;
        in_pc      = pc_next;
        in_result  = result;
        in_dest    = dest;
        in_csr_num = num;
        e.op    = op;
        e.we    = ref_rf_we(op, dest);
        e.waddr = dest;
        e.wdata = ref_rf_wdata(op, result, num);
        e.pc    = pc_next;
        exp_q.push_back(e);
        ref_commit(op, result, num); // seen by the next instruction
        pc_next = pc_next + 32'd4;
        issued++;
    endtask

    // bubble with a junk payload
    task automatic idle();
        @(posedge clk);
        #2;
        in_valid  = 1'b0;
        in_op     = OP_TLBFILL;
        in_result = rnd();
    endtask

    task automatic csr_wr(input logic [13:0] num, input logic [31:0] val);
        issue(OP_CSRWR, val, 5'd0, num);
    endtask

    task automatic csr_rd(input logic [13:0] num);
        issue(OP_CSRRD, rnd(), {1'b0, num[3:0]} + 5'd1, num);
    endtask

    task automatic write_entry(input logic [3:0] idx, input logic [18:0] vppn,
                               input logic [5:0] ps, input logic [9:0] asid,
                               input logic [31:0] elo0, input logic [31:0] elo1);
        csr_wr(`CSR_TLBIDX, {2'b00, ps, 20'd0, idx});
        csr_wr(`CSR_TLBEHI, {vppn, 13'd0});
        csr_wr(`CSR_ASID, {22'd0, asid});
        csr_wr(`CSR_TLBELO0, elo0);
        csr_wr(`CSR_TLBELO1, elo1);
        issue(OP_TLBWR, 32'd0, 5'd0, 14'd0);
    endtask

    task automatic search(input logic [18:0] vppn, input logic [9:0] asid);
        csr_wr(`CSR_TLBEHI, {vppn, 13'd0});
        csr_wr(`CSR_ASID, {22'd0, asid});
        issue(OP_TLBSRCH, 32'd0, 5'd0, 14'd0);
        csr_rd(`CSR_TLBIDX);
    endtask

    task automatic read_back(input logic [3:0] idx);
        csr_wr(`CSR_TLBIDX, {28'd0, idx});
        issue(OP_TLBRD, 32'd0, 5'd0, 14'd0);
        for (int i = 0; i < 5; i++) begin
            csr_rd(csr_list[i]);
        end
    endtask

    task automatic random_instr();
        logic [31:0] r;
        logic [31:0] val;
        logic [13:0] num;
        wb_op_t      op;
        r   = rnd();
        op  = wb_op_t'(r[2:0]);
        num = (r[5:3] < 3'd5) ? csr_list[r[5:3]] : 14'h05; // some unlisted csr
        val = rnd();
        case (num)
            `CSR_TLBIDX: val[29:24] = r[6] ? 6'd21 : 6'd12;
            `CSR_TLBEHI: val[31:13] = {15'd0, r[10:7]}; // small key space for hits
            `CSR_ASID:   val[9:0] = {8'd0, r[12:11]};
            default: ;
        endcase
        if (op == OP_INVTLB) begin
            val[9:0] = {8'd0, r[12:11]};
        end
        issue(op, val, r[17:13], num);
    endtask

    initial begin : compare
        exp_t   e;
        wb_op_t op;
        logic   v;
        wait_reset_release();
        forever begin
            @(posedge clk);
            v = in_valid;
            @(negedge clk);
            if (!v) begin
                check_rf(1'b0, 5'd0, 32'd0, "bubble");
            end else if (exp_q.size() == 0) begin
                fail_now("an instruction reached writeback that was never issued");
            end else begin
                e  = exp_q.pop_front();
                op = e.op;
                check_rf(e.we, e.waddr, e.wdata, op.name());
                check_pc(e.pc, op.name());
                checked++;
            end
        end
    end

    initial begin : stimulus
        logic [3:0]  fill_idx [6];
        logic [31:0] r;
        seed        = 33611;
        pc_next     = 32'h1c00_0000;
        issued      = 0;
        checked     = 0;
        csr_list[0] = `CSR_TLBIDX;
        csr_list[1] = `CSR_TLBEHI;
        csr_list[2] = `CSR_TLBELO0;
        csr_list[3] = `CSR_TLBELO1;
        csr_list[4] = `CSR_ASID;
        ref_reset();
        wait_reset_release();

        // csr write then read, alu to r0 and to a real register
        for (int i = 0; i < 5; i++) begin
            csr_wr(csr_list[i], rnd());
            csr_rd(csr_list[i]);
        end
        issue(OP_ALU, rnd(), 5'd0, 14'd0);
        issue(OP_ALU, rnd(), 5'd9, 14'd0);

        write_entry(4'd3, 19'h1_2345, 6'd12, 10'd5, 32'h0000_1213, 32'h0000_2217);
        write_entry(4'd7, 19'h0_0abc, 6'd12, 10'd2, 32'h0000_5541, 32'h0000_6643); // global
        write_entry(4'd10, 19'h5_5200, 6'd21, 10'd2, rnd() & 32'hffff_ffbf, rnd());
        csr_wr(`CSR_TLBIDX, 32'd0);
        search(19'h1_2345, 10'd5);
        search(19'h0_0abc, 10'd1);
        search(19'h5_52ab, 10'd2); // low 9 bits ignored
        search(19'h7_0000, 10'd5);

        read_back(4'd7);
        read_back(4'd12); // never written

        csr_wr(`CSR_TLBIDX, {2'b00, 6'd12, 24'd0});
        for (int i = 0; i < 6; i++) begin
            fill_idx[i] = m_lfsr;
            csr_wr(`CSR_TLBEHI, {19'h2_0000 + 19'(i), 13'd0});
            csr_wr(`CSR_ASID, (i % 2 != 0) ? 32'd3 : 32'd2);
            issue(OP_TLBFILL, rnd(), 5'd0, 14'd0);
        end
        for (int i = 0; i < 6; i++) begin
            read_back(fill_idx[i]);
        end

        // drop asid 2, keep globals and other asids
        issue(OP_INVTLB, 32'd2, 5'd0, 14'd0);
        for (int i = 0; i < 6; i++) begin
            search(19'h2_0000 + 19'(i), (i % 2 != 0) ? 10'd3 : 10'd2);
        end
        search(19'h0_0abc, 10'd2);
        search(19'h5_5200, 10'd2);
        search(19'h1_2345, 10'd5);

        for (int n = 0; n < 400; n++) begin
            r = rnd();
            if (r[31:29] == 3'd0) begin
                idle();
            end
            random_instr();
        end

        idle();
        wait_drain();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+rtl
+incdir+sim
rtl/tlb_pkg.sv
rtl/tlb_if.sv
rtl/wb_tlb_stage.sv
rtl/tlb_csr_file.sv
rtl/tlb_entry.sv
rtl/tlb_match_select.sv
rtl/tlb_wb_top.sv
sim/tb_tlb_wb.sv

/* Makefile */
TOP = tb_tlb_wb

sim:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
